// File: all.f
cpu_mem_pkg.sv
pipe_slot.sv
fetch_unit.sv
lsu.sv
bus_arbiter.sv
mem_top.sv
tb_clock.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_top
FILELIST  := all.f
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_top.sv
module tb_top
	import cpu_mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'hce69451b;
	localparam logic [2:0] K_WAIT   = 3'd0;
	localparam logic [2:0] K_REDIR  = 3'd1;
	localparam logic [2:0] K_LOAD   = 3'd2;
	localparam logic [2:0] K_STORE  = 3'd3;
	localparam logic [2:0] K_HOLD_F = 3'd4;
	localparam logic [2:0] K_HOLD_R = 3'd5;

	typedef struct packed {
		logic [2:0]  kind;
		logic [2:0]  funct3;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [4:0]  rd;
		logic        err;
		logic [7:0]  len;
	} step_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  funct3;
		logic [31:0] wdata;
		logic        err;
	} store_t;

	logic              clock;
	logic              reset;
	logic              redirect_valid_i;
	logic [ADDR_W-1:0] redirect_pc_i;
	logic              fetch_valid_o;
	fetch_out_t        fetch_o;
	logic              fetch_ready_i;
	logic              lsu_req_valid_i;
	lsu_req_t          lsu_req_i;
	logic              lsu_req_ready_o;
	logic              lsu_rsp_valid_o;
	lsu_rsp_t          lsu_rsp_o;
	logic              lsu_rsp_ready_i;
	logic              ar_valid_o;
	bus_ar_t           ar_o;
	logic              ar_ready_i;
	logic              r_valid_i;
	bus_r_t            r_i;
	logic              r_ready_o;
	logic              aw_valid_o;
	bus_ar_t           aw_o;
	logic              aw_ready_i;
	logic              w_valid_o;
	bus_w_t            w_o;
	logic              w_ready_i;
	logic              b_valid_i;
	bus_b_t            b_i;
	logic              b_ready_o;

	logic              hold_fetch;
	logic              hold_rsp;
	int                errors;
	int                fetch_count;
	int                lsu_count;
	step_t             steps[$];
	step_t             lsu_exp[$];
	store_t            store_exp[$];
	rd_req_t           load_req_exp[$];
	logic [63:0]       lsu_words[$];
	logic [63:0]       mem[logic [28:0]];

	tb_clock clk0 (
		.clock (clock),
		.reset (reset)
	);

	mem_top dut0 (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// unwritten words come from the full word address
	function automatic logic [63:0] mem_word(input logic [31:0] a);
		logic [31:0] lo;
		if (mem.exists(a[31:3])) begin
			return mem[a[31:3]];
		end
		lo = xorshift({a[31:3], 3'b000} ^ SEED);
		return {xorshift(lo), lo};
	endfunction

	function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] a,
			input logic [63:0] w);
		logic [63:0] sh;
		sh = w >> (8 * int'(a[2:0]));
		case (f3)
			3'b000:  return {{24{sh[7]}}, sh[7:0]};
			3'b001:  return {{16{sh[15]}}, sh[15:0]};
			3'b100:  return {24'd0, sh[7:0]};
			3'b101:  return {16'd0, sh[15:0]};
			default: return sh[31:0];
		endcase
	endfunction

	function automatic logic [7:0] store_strb(input logic [2:0] f3, input logic [31:0] a);
		logic [7:0] s;
		int n;
		s = 8'h00;
		n = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
		for (int i = 0; i < n; i++) begin
			if (int'(a[2:0]) + i < 8) s[int'(a[2:0]) + i] = 1'b1;
		end
		return s;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic add_step(input logic [2:0] kind, input logic [2:0] f3, input logic [31:0] addr,
			input logic [31:0] wdata, input logic err, input int len);
		step_t s;
		s.kind   = kind;
		s.funct3 = f3;
		s.addr   = addr;
		s.wdata  = wdata;
		s.rd     = 5'(steps.size() + 1);
		s.err    = err;
		s.len    = 8'(len);
		steps.push_back(s);
	endtask

	task automatic build_table();
		add_step(K_WAIT, 3'b000, 32'h0, 32'h0, 1'b0, 40);
		for (int off = 0; off < 8; off++) begin
			add_step(K_LOAD, 3'b000, 32'h1000_0040 + 32'(off), 32'h0, 1'b0, 0);
			add_step(K_LOAD, 3'b100, 32'h1000_0040 + 32'(off), 32'h0, 1'b0, 0);
		end
		for (int off = 0; off < 8; off += 2) begin
			add_step(K_LOAD, 3'b001, 32'h1000_0040 + 32'(off), 32'h0, 1'b0, 0);
			add_step(K_LOAD, 3'b101, 32'h1000_0040 + 32'(off), 32'h0, 1'b0, 0);
		end
		add_step(K_LOAD, 3'b010, 32'h1000_0040, 32'h0, 1'b0, 0);
		add_step(K_LOAD, 3'b010, 32'h1000_0044, 32'h0, 1'b0, 0);
		add_step(K_STORE, 3'b010, 32'h1000_0100, 32'h1234_5678, 1'b0, 0);
		add_step(K_STORE, 3'b000, 32'h1000_0101, 32'h0000_00a5, 1'b0, 0);
		add_step(K_STORE, 3'b001, 32'h1000_0106, 32'h0000_beef, 1'b0, 0);
		add_step(K_LOAD, 3'b010, 32'h1000_0100, 32'h0, 1'b0, 0);
		add_step(K_LOAD, 3'b010, 32'h1000_0104, 32'h0, 1'b0, 0);
		add_step(K_LOAD, 3'b100, 32'h1000_0101, 32'h0, 1'b0, 0);
		add_step(K_LOAD, 3'b001, 32'h1000_0106, 32'h0, 1'b0, 0);
		add_step(K_REDIR, 3'b000, 32'h8000_1000, 32'h0, 1'b0, 0);
		add_step(K_WAIT, 3'b000, 32'h0, 32'h0, 1'b0, 30);
		add_step(K_HOLD_F, 3'b000, 32'h0, 32'h0, 1'b0, 20);
		add_step(K_LOAD, 3'b010, 32'h1000_0048, 32'h0, 1'b0, 0);
		add_step(K_HOLD_R, 3'b000, 32'h0, 32'h0, 1'b0, 15);
		add_step(K_REDIR, 3'b000, 32'h8000_2004, 32'h0, 1'b0, 0);
		add_step(K_WAIT, 3'b000, 32'h0, 32'h0, 1'b0, 10);
		add_step(K_STORE, 3'b010, 32'h1000_0200, 32'hdead_beef, 1'b1, 0);
		add_step(K_LOAD, 3'b010, 32'h1000_0200, 32'h0, 1'b0, 0);
		add_step(K_WAIT, 3'b000, 32'h0, 32'h0, 1'b0, 40);
	endtask

	task automatic issue_request(input step_t s);
		store_t  st;
		rd_req_t ld;
		@(negedge clock);
		lsu_req_valid_i <= 1'b1;
		lsu_req_i <= '{op: (s.kind == K_STORE) ? LS_STORE : LS_LOAD, funct3: s.funct3,
			addr: s.addr, wdata: s.wdata, rd: s.rd};
		lsu_exp.push_back(s);
		if (s.kind == K_STORE) begin
			st = '{addr: s.addr, funct3: s.funct3, wdata: s.wdata, err: s.err};
			store_exp.push_back(st);
		end else begin
			ld = '{addr: s.addr, size: {1'b0, s.funct3[1:0]}};
			load_req_exp.push_back(ld);
		end
		// ready is registered, so its value here holds through the next edge
		while (!lsu_req_ready_o) @(negedge clock);
		@(negedge clock);
		lsu_req_valid_i <= 1'b0;
	endtask

	initial begin : stimulus
		errors           = 0;
		fetch_count      = 0;
		lsu_count        = 0;
		redirect_valid_i = 1'b0;
		redirect_pc_i    = '0;
		lsu_req_valid_i  = 1'b0;
		lsu_req_i        = '0;
		hold_fetch       = 1'b0;
		hold_rsp         = 1'b0;
		build_table();
		repeat (2) @(negedge clock);
		check("reset_outputs", 64'h0, 64'({fetch_valid_o, lsu_rsp_valid_o, ar_valid_o,
			aw_valid_o, w_valid_o, r_ready_o, b_ready_o, lsu_req_ready_o}));
		wait (!reset);
		foreach (steps[i]) begin
			case (steps[i].kind)
				K_WAIT: repeat (int'(steps[i].len)) @(negedge clock);
				K_REDIR: begin
					@(negedge clock);
					redirect_valid_i <= 1'b1;
					redirect_pc_i    <= steps[i].addr;
					@(negedge clock);
					redirect_valid_i <= 1'b0;
				end
				K_HOLD_F: begin
					@(negedge clock);
					hold_fetch <= 1'b1;
					repeat (int'(steps[i].len)) @(negedge clock);
					hold_fetch <= 1'b0;
				end
				K_HOLD_R: begin
					@(negedge clock);
					hold_rsp <= 1'b1;
					repeat (int'(steps[i].len)) @(negedge clock);
					hold_rsp <= 1'b0;
				end
				default: issue_request(steps[i]);
			endcase
		end
		while (lsu_exp.size() != 0) @(negedge clock);
		repeat (20) @(negedge clock);
		check("fetch_seen", 64'h1, 64'(fetch_count > 0));
		$display("errors %0d, fetches %0d, lsu responses %0d", errors, fetch_count, lsu_count);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// bus slave with random ready and response delays
	initial begin : bus_responder
		logic [31:0] r;
		logic        ar_vq;
		logic        aw_vq;
		logic        w_vq;
		logic        r_rq;
		logic        b_rq;
		bus_ar_t     ar_q;
		bus_ar_t     aw_q;
		bus_w_t      w_q;
		bus_ar_t     rd_txn;
		logic        rd_busy;
		logic        wr_busy;
		logic        r_sent;
		logic        b_pend;
		logic        b_err;
		logic        aw_got;
		logic        w_got;
		int          r_wait;
		int          b_wait;
		store_t      st;
		rd_req_t     lreq;
		logic [7:0]  strb;
		logic [63:0] lane;
		logic [63:0] mask;
		logic [63:0] word;
		r = SEED;
		{ar_vq, aw_vq, w_vq, r_rq, b_rq} = '0;
		{rd_busy, wr_busy, r_sent, b_pend, b_err, aw_got, w_got} = '0;
		ar_q = '0;
		aw_q = '0;
		w_q = '0;
		rd_txn = '0;
		r_wait = 0;
		b_wait = 0;
		ar_ready_i = 1'b0;
		aw_ready_i = 1'b0;
		w_ready_i  = 1'b0;
		r_valid_i  = 1'b0;
		r_i        = '0;
		b_valid_i  = 1'b0;
		b_i        = '0;
		forever begin
			@(negedge clock);
			if (r_valid_i && r_rq) begin
				r_valid_i <= 1'b0;
				rd_busy = 1'b0;
				r_sent  = 1'b0;
			end
			if (b_valid_i && b_rq) begin
				b_valid_i <= 1'b0;
				wr_busy = 1'b0;
				b_pend  = 1'b0;
			end
			if (ar_vq && ar_ready_i) begin
				check("bus_overlap_ar", 64'h0, 64'(rd_busy || wr_busy));
				check("ar_id", 64'(ar_q.addr[31] ? ID_FETCH : ID_LSU), 64'(ar_q.id));
				if (ar_q.addr[31]) begin
					check("ar_size_fetch", 64'(SIZE_WORD), 64'(ar_q.size));
				end else if (load_req_exp.size() == 0) begin
					errors++;
					$display("read on the bus with no load outstanding");
				end else begin
					lreq = load_req_exp.pop_front();
					check("ar_addr", 64'(lreq.addr), 64'(ar_q.addr));
					check("ar_size", 64'(lreq.size), 64'(ar_q.size));
				end
				rd_busy = 1'b1;
				rd_txn  = ar_q;
				r_wait  = int'(r[1:0]);
			end
			if (aw_vq && aw_ready_i) begin
				check("bus_overlap_aw", 64'h0, 64'(rd_busy || (wr_busy && !w_got)));
				check("aw_id", 64'(ID_LSU), 64'(aw_q.id));
				wr_busy = 1'b1;
				aw_got  = 1'b1;
			end
			if (w_vq && w_ready_i) begin
				check("w_last", 64'h1, 64'(w_q.last));
				wr_busy = 1'b1;
				w_got   = 1'b1;
			end
			if (aw_got && w_got) begin
				aw_got = 1'b0;
				w_got  = 1'b0;
				if (store_exp.size() == 0) begin
					errors++;
					$display("write on the bus with no store outstanding");
				end else begin
					st = store_exp.pop_front();
					strb = store_strb(st.funct3, st.addr);
					lane = 64'h0;
					mask = 64'h0;
					for (int i = 0; i < 8; i++) begin
						if (strb[i]) begin
							lane[i*8 +: 8] = st.wdata[(i - int'(st.addr[2:0]))*8 +: 8];
							mask[i*8 +: 8] = 8'hff;
						end
					end
					check("aw_addr", 64'(st.addr), 64'(aw_q.addr));
					check("aw_size", 64'({1'b0, st.funct3[1:0]}), 64'(aw_q.size));
					check("w_strb", 64'(strb), 64'(w_q.strb));
					check("w_data", lane, w_q.data & mask);
					b_err = st.err;
				end
				word = mem_word(aw_q.addr);
				for (int i = 0; i < 8; i++) begin
					if (w_q.strb[i]) word[i*8 +: 8] = w_q.data[i*8 +: 8];
				end
				mem[aw_q.addr[31:3]] = word;
				b_pend = 1'b1;
				b_wait = int'(r[3:2]);
			end
			ar_vq = ar_valid_o;
			ar_q  = ar_o;
			aw_vq = aw_valid_o;
			aw_q  = aw_valid_o ? aw_o : aw_q;
			w_vq  = w_valid_o;
			w_q   = w_valid_o ? w_o : w_q;
			r_rq  = r_ready_o;
			b_rq  = b_ready_o;
			ar_ready_i <= ar_valid_o && (r[1:0] != 2'b00);
			aw_ready_i <= aw_valid_o && (r[4:3] != 2'b00);
			w_ready_i  <= w_valid_o && (r[6:5] != 2'b00);
			if (rd_busy && !r_sent) begin
				if (r_wait == 0) begin
					word = mem_word(rd_txn.addr);
					if (rd_txn.id == ID_LSU) lsu_words.push_back(word);
					r_valid_i <= 1'b1;
					r_i <= '{data: word, id: rd_txn.id, resp: 2'b00, last: 1'b1};
					r_sent = 1'b1;
				end else begin
					r_wait--;
				end
			end
			if (b_pend && !b_valid_i) begin
				if (b_wait == 0) begin
					b_valid_i <= 1'b1;
					b_i <= '{id: ID_LSU, resp: b_err ? 2'b10 : 2'b00};
				end else begin
					b_wait--;
				end
			end
			r = xorshift(r);
		end
	end

	initial begin : fetch_consumer
		logic [31:0] r;
		logic        vq;
		fetch_out_t  oq;
		logic [31:0] exp_pc;
		logic [31:0] old_pc;
		logic        stale_ok;
		logic [63:0] w;
		r = xorshift(SEED);
		vq = 1'b0;
		oq = '0;
		exp_pc = RESET_PC;
		old_pc = '0;
		stale_ok = 1'b0;
		fetch_ready_i = 1'b0;
		forever begin
			@(negedge clock);
			if (vq && fetch_ready_i) begin
				// one entry from before a redirect may still drain
				if (stale_ok && oq.pc == old_pc && oq.pc != exp_pc) begin
					stale_ok = 1'b0;
				end else begin
					check("fetch_pc", 64'(exp_pc), 64'(oq.pc));
					exp_pc = exp_pc + 32'd4;
					stale_ok = 1'b0;
				end
				w = mem_word(oq.pc);
				check("fetch_inst", 64'(oq.pc[2] ? w[63:32] : w[31:0]), 64'(oq.inst));
				fetch_count++;
			end else if (vq) begin
				check("fetch_hold_valid", 64'h1, 64'(fetch_valid_o));
				check("fetch_hold_data", oq, fetch_o);
			end
			if (redirect_valid_i) begin
				old_pc = exp_pc;
				exp_pc = redirect_pc_i;
				stale_ok = 1'b1;
			end
			vq = fetch_valid_o;
			oq = fetch_o;
			fetch_ready_i <= !hold_fetch && (r[2:0] != 3'b000);
			r = xorshift(r);
		end
	end

	initial begin : lsu_consumer
		logic [31:0] r;
		logic        vq;
		lsu_rsp_t    oq;
		step_t       e;
		logic [63:0] w;
		r = xorshift(xorshift(SEED));
		vq = 1'b0;
		oq = '0;
		lsu_rsp_ready_i = 1'b0;
		forever begin
			@(negedge clock);
			// no new request while a response is stuck in the slot
			check("lsu_req_ready", 64'h1,
				64'(!lsu_req_ready_o || !lsu_rsp_valid_o || lsu_rsp_ready_i));
			if (vq && lsu_rsp_ready_i) begin
				if (lsu_exp.size() == 0) begin
					errors++;
					$display("load/store response for rd %0d with no request outstanding", oq.rd);
				end else begin
					e = lsu_exp.pop_front();
					check("lsu_rd", 64'(e.rd), 64'(oq.rd));
					check("lsu_err", 64'(e.err), 64'(oq.err));
					if (e.kind == K_LOAD) begin
						if (lsu_words.size() == 0) begin
							errors++;
							$display("load response for rd %0d without a bus read", oq.rd);
						end else begin
							w = lsu_words.pop_front();
							check("lsu_load", 64'(load_value(e.funct3, e.addr, w)), 64'(oq.data));
						end
					end else begin
						check("lsu_store_data", 64'h0, 64'(oq.data));
					end
					lsu_count++;
				end
			end else if (vq) begin
				check("lsu_hold_valid", 64'h1, 64'(lsu_rsp_valid_o));
				check("lsu_hold_data", 64'(oq), 64'(lsu_rsp_o));
			end
			vq = lsu_rsp_valid_o;
			oq = lsu_rsp_o;
			lsu_rsp_ready_i <= !hold_rsp && (r[1:0] != 2'b00);
			r = xorshift(r);
		end
	end

	initial begin : watchdog
		int limit;
		#1;
		limit = steps.size() * 200;
		repeat (limit) @(posedge clock);
		$display("timeout, run did not finish within %0d cycles", limit);
		$display("Errors found");
		$finish;
	end

endmodule

// File: tb_clock.sv
module tb_clock (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: mem_top.sv
module mem_top
	import cpu_mem_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic              redirect_valid_i,
	input  logic [ADDR_W-1:0] redirect_pc_i,
	output logic              fetch_valid_o,
	output fetch_out_t        fetch_o,
	input  logic              fetch_ready_i,
	input  logic              lsu_req_valid_i,
	input  lsu_req_t          lsu_req_i,
	output logic              lsu_req_ready_o,
	output logic              lsu_rsp_valid_o,
	output lsu_rsp_t          lsu_rsp_o,
	input  logic              lsu_rsp_ready_i,
	output logic              ar_valid_o,
	output bus_ar_t           ar_o,
	input  logic              ar_ready_i,
	input  logic              r_valid_i,
	input  bus_r_t            r_i,
	output logic              r_ready_o,
	output logic              aw_valid_o,
	output bus_ar_t           aw_o,
	input  logic              aw_ready_i,
	output logic              w_valid_o,
	output bus_w_t            w_o,
	input  logic              w_ready_i,
	input  logic              b_valid_i,
	input  bus_b_t            b_i,
	output logic              b_ready_o
);

	// fetch side of the arbiter
	logic    f_rd_req_valid;
	rd_req_t f_rd_req;
	logic    f_rd_req_ready;
	logic    f_rd_rsp_valid;
	rd_rsp_t f_rd_rsp;

	// load/store side
	logic    l_rd_req_valid;
	rd_req_t l_rd_req;
	logic    l_rd_req_ready;
	logic    l_rd_rsp_valid;
	rd_rsp_t l_rd_rsp;
	logic    l_wr_req_valid;
	wr_req_t l_wr_req;
	logic    l_wr_req_ready;
	logic    l_wr_done;
	logic    l_wr_err;

	fetch_unit fetch0 (
		.clock            (clock),
		.reset            (reset),
		.redirect_valid_i (redirect_valid_i),
		.redirect_pc_i    (redirect_pc_i),
		.rd_req_valid_o   (f_rd_req_valid),
		.rd_req_o         (f_rd_req),
		.rd_req_ready_i   (f_rd_req_ready),
		.rd_rsp_valid_i   (f_rd_rsp_valid),
		.rd_rsp_i         (f_rd_rsp),
		.fetch_valid_o    (fetch_valid_o),
		.fetch_o          (fetch_o),
		.fetch_ready_i    (fetch_ready_i)
	);

	lsu lsu0 (
		.clock          (clock),
		.reset          (reset),
		.req_valid_i    (lsu_req_valid_i),
		.req_i          (lsu_req_i),
		.req_ready_o    (lsu_req_ready_o),
		.rd_req_valid_o (l_rd_req_valid),
		.rd_req_o       (l_rd_req),
		.rd_req_ready_i (l_rd_req_ready),
		.rd_rsp_valid_i (l_rd_rsp_valid),
		.rd_rsp_i       (l_rd_rsp),
		.wr_req_valid_o (l_wr_req_valid),
		.wr_req_o       (l_wr_req),
		.wr_req_ready_i (l_wr_req_ready),
		.wr_done_i      (l_wr_done),
		.wr_err_i       (l_wr_err),
		.rsp_valid_o    (lsu_rsp_valid_o),
		.rsp_o          (lsu_rsp_o),
		.rsp_ready_i    (lsu_rsp_ready_i)
	);

	bus_arbiter arb0 (
		.clock            (clock),
		.reset            (reset),
		.f_rd_req_valid_i (f_rd_req_valid),
		.f_rd_req_i       (f_rd_req),
		.f_rd_req_ready_o (f_rd_req_ready),
		.f_rd_rsp_valid_o (f_rd_rsp_valid),
		.f_rd_rsp_o       (f_rd_rsp),
		.l_rd_req_valid_i (l_rd_req_valid),
		.l_rd_req_i       (l_rd_req),
		.l_rd_req_ready_o (l_rd_req_ready),
		.l_rd_rsp_valid_o (l_rd_rsp_valid),
		.l_rd_rsp_o       (l_rd_rsp),
		.l_wr_req_valid_i (l_wr_req_valid),
		.l_wr_req_i       (l_wr_req),
		.l_wr_req_ready_o (l_wr_req_ready),
		.l_wr_done_o      (l_wr_done),
		.l_wr_err_o       (l_wr_err),
		.ar_valid_o       (ar_valid_o),
		.ar_o             (ar_o),
		.ar_ready_i       (ar_ready_i),
		.r_valid_i        (r_valid_i),
		.r_i              (r_i),
		.r_ready_o        (r_ready_o),
		.aw_valid_o       (aw_valid_o),
		.aw_o             (aw_o),
		.aw_ready_i       (aw_ready_i),
		.w_valid_o        (w_valid_o),
		.w_o              (w_o),
		.w_ready_i        (w_ready_i),
		.b_valid_i        (b_valid_i),
		.b_i              (b_i),
		.b_ready_o        (b_ready_o)
	);

endmodule

// File: bus_arbiter.sv
module bus_arbiter
	import cpu_mem_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    f_rd_req_valid_i,
	input  rd_req_t f_rd_req_i,
	output logic    f_rd_req_ready_o,
	output logic    f_rd_rsp_valid_o,
	output rd_rsp_t f_rd_rsp_o,
	input  logic    l_rd_req_valid_i,
	input  rd_req_t l_rd_req_i,
	output logic    l_rd_req_ready_o,
	output logic    l_rd_rsp_valid_o,
	output rd_rsp_t l_rd_rsp_o,
	input  logic    l_wr_req_valid_i,
	input  wr_req_t l_wr_req_i,
	output logic    l_wr_req_ready_o,
	output logic    l_wr_done_o,
	output logic    l_wr_err_o,
	output logic    ar_valid_o,
	output bus_ar_t ar_o,
	input  logic    ar_ready_i,
	input  logic    r_valid_i,
	input  bus_r_t  r_i,
	output logic    r_ready_o,
	output logic    aw_valid_o,
	output bus_ar_t aw_o,
	input  logic    aw_ready_i,
	output logic    w_valid_o,
	output bus_w_t  w_o,
	input  logic    w_ready_i,
	input  logic    b_valid_i,
	input  bus_b_t  b_i,
	output logic    b_ready_o
);

	typedef enum logic [2:0] {A_IDLE, A_AR, A_R, A_W, A_B} astate_e;

	astate_e          state_q;
	bus_ar_t          addr_q;
	bus_w_t           w_q;
	logic             aw_done_q;
	logic             w_done_q;
	logic             f_pulse_q;
	logic             l_pulse_q;
	logic             wr_pulse_q;
	logic [BUS_W-1:0] data_q;
	logic             err_q;
	logic             grant_lw;
	logic             grant_lr;
	logic             grant_fr;
	logic             r_fire;
	logic             b_fire;
	logic             aw_fire;
	logic             w_fire;

	// lsu write, then lsu read, then fetch
	assign grant_lw = (state_q == A_IDLE) && l_wr_req_valid_i;
	assign grant_lr = (state_q == A_IDLE) && !l_wr_req_valid_i && l_rd_req_valid_i;
	assign grant_fr = (state_q == A_IDLE) && !l_wr_req_valid_i && !l_rd_req_valid_i &&
		f_rd_req_valid_i;

	assign l_wr_req_ready_o = grant_lw;
	assign l_rd_req_ready_o = grant_lr;
	assign f_rd_req_ready_o = grant_fr;

	assign ar_valid_o = (state_q == A_AR);
	assign ar_o       = addr_q;
	assign r_ready_o  = (state_q == A_R);
	assign aw_valid_o = (state_q == A_W) && !aw_done_q;
	assign aw_o       = addr_q;
	assign w_valid_o  = (state_q == A_W) && !w_done_q;
	assign w_o        = w_q;
	assign b_ready_o  = (state_q == A_B);

	assign r_fire  = r_valid_i && r_ready_o;
	assign b_fire  = b_valid_i && b_ready_o;
	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire  = w_valid_o && w_ready_i;

	assign f_rd_rsp_valid_o = f_pulse_q;
	assign f_rd_rsp_o       = '{data: data_q, err: err_q};
	assign l_rd_rsp_valid_o = l_pulse_q;
	assign l_rd_rsp_o       = '{data: data_q, err: err_q};
	assign l_wr_done_o      = wr_pulse_q;
	assign l_wr_err_o       = err_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q    <= A_IDLE;
			aw_done_q  <= 1'b0;
			w_done_q   <= 1'b0;
			f_pulse_q  <= 1'b0;
			l_pulse_q  <= 1'b0;
			wr_pulse_q <= 1'b0;
		end else begin
			// read data goes back to whoever owns the id
			f_pulse_q  <= r_fire && (addr_q.id == ID_FETCH);
			l_pulse_q  <= r_fire && (addr_q.id == ID_LSU);
			wr_pulse_q <= b_fire;
			case (state_q)
				A_IDLE: begin
					if (grant_lw) state_q <= A_W;
					else if (grant_lr || grant_fr) state_q <= A_AR;
				end
				A_AR: if (ar_ready_i) state_q <= A_R;
				A_R:  if (r_fire) state_q <= A_IDLE;
				A_W: begin
					aw_done_q <= aw_done_q || aw_fire;
					w_done_q  <= w_done_q || w_fire;
					if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
						state_q   <= A_B;
						aw_done_q <= 1'b0;
						w_done_q  <= 1'b0;
					end
				end
				A_B: if (b_fire) state_q <= A_IDLE;
				default: state_q <= A_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (grant_lw) begin
			addr_q <= '{addr: l_wr_req_i.addr, id: ID_LSU, size: l_wr_req_i.size};
			w_q    <= '{data: l_wr_req_i.data, strb: l_wr_req_i.strb, last: 1'b1};
		end else if (grant_lr) begin
			addr_q <= '{addr: l_rd_req_i.addr, id: ID_LSU, size: l_rd_req_i.size};
		end else if (grant_fr) begin
			addr_q <= '{addr: f_rd_req_i.addr, id: ID_FETCH, size: f_rd_req_i.size};
		end
		if (r_fire) begin
			data_q <= r_i.data;
			err_q  <= (r_i.resp != RESP_OKAY);
		end else if (b_fire) begin
			err_q <= (b_i.resp != RESP_OKAY);
		end
	end

endmodule

// File: lsu.sv
module lsu
	import cpu_mem_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     req_valid_i,
	input  lsu_req_t req_i,
	output logic     req_ready_o,
	output logic     rd_req_valid_o,
	output rd_req_t  rd_req_o,
	input  logic     rd_req_ready_i,
	input  logic     rd_rsp_valid_i,
	input  rd_rsp_t  rd_rsp_i,
	output logic     wr_req_valid_o,
	output wr_req_t  wr_req_o,
	input  logic     wr_req_ready_i,
	input  logic     wr_done_i,
	input  logic     wr_err_i,
	output logic     rsp_valid_o,
	output lsu_rsp_t rsp_o,
	input  logic     rsp_ready_i
);

	typedef enum logic [2:0] {L_IDLE, L_RD, L_WR, L_WAIT, L_DONE} lstate_e;

	lstate_e           state_q;
	logic              ready_q;
	lsu_req_t          req_q;
	lsu_rsp_t          rsp_q;
	logic              accept;
	logic              slot_in_ready;
	logic [5:0]        lane_shift;
	logic [BUS_W-1:0]  beat;
	logic [XLEN-1:0]   load_val;
	logic [STRB_W-1:0] strb_base;

	assign accept      = req_valid_i && ready_q;
	assign req_ready_o = ready_q;
	assign lane_shift  = {req_q.addr[2:0], 3'b000};
	assign beat        = rd_rsp_i.data >> lane_shift;

	always_comb begin
		case (req_q.funct3)
			3'b000:  load_val = {{24{beat[7]}}, beat[7:0]};
			3'b001:  load_val = {{16{beat[15]}}, beat[15:0]};
			3'b100:  load_val = {24'd0, beat[7:0]};
			3'b101:  load_val = {16'd0, beat[15:0]};
			default: load_val = beat[31:0];
		endcase
	end

	always_comb begin
		case (req_q.funct3[1:0])
			2'b00:   strb_base = 8'h01;
			2'b01:   strb_base = 8'h03;
			default: strb_base = 8'h0f;
		endcase
	end

	assign rd_req_valid_o = (state_q == L_RD);
	assign rd_req_o.addr  = req_q.addr;
	assign rd_req_o.size  = {1'b0, req_q.funct3[1:0]};
	assign wr_req_valid_o = (state_q == L_WR);
	assign wr_req_o.addr  = req_q.addr;
	assign wr_req_o.size  = {1'b0, req_q.funct3[1:0]};
	assign wr_req_o.data  = BUS_W'(req_q.wdata) << lane_shift;
	assign wr_req_o.strb  = strb_base << req_q.addr[2:0];

	// ready comes back a cycle after idle, once the slot has room
	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= L_IDLE;
			ready_q <= 1'b0;
		end else begin
			case (state_q)
				L_IDLE: begin
					ready_q <= !accept && slot_in_ready;
					if (accept) state_q <= (req_i.op == LS_STORE) ? L_WR : L_RD;
				end
				L_RD:   if (rd_req_ready_i) state_q <= L_WAIT;
				L_WR:   if (wr_req_ready_i) state_q <= L_WAIT;
				L_WAIT: if (rd_rsp_valid_i || wr_done_i) state_q <= L_DONE;
				L_DONE: if (slot_in_ready) state_q <= L_IDLE;
				default: state_q <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) req_q <= req_i;
		if (state_q == L_WAIT && rd_rsp_valid_i) begin
			rsp_q <= '{rd: req_q.rd, data: load_val, err: rd_rsp_i.err};
		end else if (state_q == L_WAIT && wr_done_i) begin
			rsp_q <= '{rd: req_q.rd, data: '0, err: wr_err_i};
		end
	end

	pipe_slot #(.payload_t(lsu_rsp_t)) slot0 (
		.clock       (clock),
		.reset       (reset),
		.in_valid_i  (state_q == L_DONE),
		.in_i        (rsp_q),
		.in_ready_o  (slot_in_ready),
		.out_valid_o (rsp_valid_o),
		.out_o       (rsp_o),
		.out_ready_i (rsp_ready_i)
	);

endmodule

// File: fetch_unit.sv
module fetch_unit
	import cpu_mem_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic              redirect_valid_i,
	input  logic [ADDR_W-1:0] redirect_pc_i,
	output logic              rd_req_valid_o,
	output rd_req_t           rd_req_o,
	input  logic              rd_req_ready_i,
	input  logic              rd_rsp_valid_i,
	input  rd_rsp_t           rd_rsp_i,
	output logic              fetch_valid_o,
	output fetch_out_t        fetch_o,
	input  logic              fetch_ready_i
);

	typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT} fstate_e;

	fstate_e           state_q;
	logic [ADDR_W-1:0] pc_q;
	logic [ADDR_W-1:0] req_addr_q;
	logic              discard_q;
	logic              rsp_hit;
	logic              slot_in_valid;
	logic              slot_in_ready;
	fetch_out_t        slot_in;

	assign rsp_hit        = (state_q == F_WAIT) && rd_rsp_valid_i;
	// drop data that belongs to the pc before a redirect
	assign slot_in_valid  = rsp_hit && !discard_q && !redirect_valid_i;
	assign slot_in.pc     = req_addr_q;
	assign slot_in.inst   = req_addr_q[2] ? rd_rsp_i.data[63:32] : rd_rsp_i.data[31:0];
	assign rd_req_valid_o = (state_q == F_REQ);
	assign rd_req_o.addr  = req_addr_q;
	assign rd_req_o.size  = SIZE_WORD;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q   <= F_IDLE;
			pc_q      <= RESET_PC;
			discard_q <= 1'b0;
		end else begin
			case (state_q)
				F_IDLE: if (slot_in_ready && !redirect_valid_i) state_q <= F_REQ;
				F_REQ:  if (rd_req_ready_i) state_q <= F_WAIT;
				F_WAIT: if (rd_rsp_valid_i) state_q <= F_IDLE;
				default: state_q <= F_IDLE;
			endcase
			if (redirect_valid_i) begin
				pc_q <= redirect_pc_i;
			end else if (slot_in_valid) begin
				pc_q <= pc_q + 32'd4;
			end
			if (rsp_hit) begin
				discard_q <= 1'b0;
			end else if (redirect_valid_i && state_q != F_IDLE) begin
				discard_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == F_IDLE) begin
			req_addr_q <= pc_q;
		end
	end

	pipe_slot #(.payload_t(fetch_out_t)) slot0 (
		.clock       (clock),
		.reset       (reset),
		.in_valid_i  (slot_in_valid),
		.in_i        (slot_in),
		.in_ready_o  (slot_in_ready),
		.out_valid_o (fetch_valid_o),
		.out_o       (fetch_o),
		.out_ready_i (fetch_ready_i)
	);

endmodule

// File: pipe_slot.sv
module pipe_slot #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     in_valid_i,
	input  payload_t in_i,
	output logic     in_ready_o,
	output logic     out_valid_o,
	output payload_t out_o,
	input  logic     out_ready_i
);

	logic     full_q;
	payload_t data_q;

	// a full slot can still take a new entry in the cycle it drains
	assign in_ready_o  = !full_q || out_ready_i;
	assign out_valid_o = full_q;
	assign out_o       = data_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			full_q <= 1'b0;
		end else if (in_valid_i && in_ready_o) begin
			full_q <= 1'b1;
		end else if (out_ready_i) begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_i;
		end
	end

endmodule

// File: cpu_mem_pkg.sv
package cpu_mem_pkg;

	localparam int ADDR_W = 32;
	localparam int XLEN   = 32;
	localparam int BUS_W  = 64;
	localparam int STRB_W = 8;
	localparam int ID_W   = 4;

	localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

	// transaction ids on the shared master port
	localparam logic [ID_W-1:0] ID_FETCH = 4'd0;
	localparam logic [ID_W-1:0] ID_LSU   = 4'd1;

	localparam logic [2:0] SIZE_WORD = 3'd2;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic [XLEN-1:0]   inst;
	} fetch_out_t;

	typedef enum logic {
		LS_LOAD  = 1'b0,
		LS_STORE = 1'b1
	} ls_op_e;

	typedef struct packed {
		ls_op_e            op;
		logic [2:0]        funct3;
		logic [ADDR_W-1:0] addr;
		logic [XLEN-1:0]   wdata;
		logic [4:0]        rd;
	} lsu_req_t;

	typedef struct packed {
		logic [4:0]      rd;
		logic [XLEN-1:0] data;
		logic            err;
	} lsu_rsp_t;

	// client side of the arbiter
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        size;
	} rd_req_t;

	typedef struct packed {
		logic [BUS_W-1:0] data;
		logic             err;
	} rd_rsp_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        size;
		logic [BUS_W-1:0]  data;
		logic [STRB_W-1:0] strb;
	} wr_req_t;

	// bus channels, aw shares the ar layout
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0]   id;
		logic [2:0]        size;
	} bus_ar_t;

	typedef struct packed {
		logic [BUS_W-1:0]  data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} bus_w_t;

	typedef struct packed {
		logic [BUS_W-1:0] data;
		logic [ID_W-1:0]  id;
		logic [1:0]       resp;
		logic             last;
	} bus_r_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [1:0]      resp;
	} bus_b_t;

endpackage
